//--- verilog/vga_pkg.sv
package vga_pkg;

    ////////////////////////////////////////
    // Video timing bundle
    typedef struct packed {
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
    } vga_timing_t;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Per-pixel result of the text path
    typedef struct packed {
        logic in_box;
        logic lit;
    } text_layer_t;

    // Per-pixel result of the pointer path
    typedef struct packed {
        logic cursor;
        logic hover;
        logic pressed;
    } pointer_layer_t;

    ////////////////////////////////////////
    // Palette
    localparam rgb_t BLANK_COLOUR   = 12'h000;
    localparam rgb_t BG_COLOUR      = 12'h112;
    localparam rgb_t TEXT_BG_COLOUR = 12'h0f0;
    localparam rgb_t LETTER_COLOUR  = 12'h00f;
    localparam rgb_t HOVER_COLOUR   = 12'hff0;
    localparam rgb_t PRESS_COLOUR   = 12'hf80;
    localparam rgb_t CURSOR_COLOUR  = 12'hfff;

    // Text grid, cell is 8 wide and 16 tall (glyph rows doubled)
    localparam int BOX_COLS = 16;
    localparam int BOX_ROWS = 5;
    localparam int CELL_W   = 8;
    localparam int CELL_H   = 16;

    // Glyph codes, row-major, code 0 is a blank cell
    localparam logic [2:0] BOX_TEXT [0:79] = '{
        3'd0, 3'd1, 3'd2, 3'd3, 3'd3, 3'd4, 3'd0, 3'd5, 3'd4, 3'd6, 3'd3, 3'd7, 3'd0, 3'd0, 3'd0, 3'd0,
        3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0,
        3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0,
        3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0,
        3'd1, 3'd1, 3'd2, 3'd2, 3'd0, 3'd5, 3'd5, 3'd6, 3'd6, 3'd0, 3'd7, 3'd7, 3'd4, 3'd4, 3'd3, 3'd3
    };

endpackage

//--- verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic                 clk,
    input  logic                 rst,
    output vga_pkg::vga_timing_t timing
);

    // Frame geometry in counter terms
    localparam logic [11:0] H_LAST     = 12'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [11:0] V_LAST     = 12'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [11:0] H_VIS_END  = 12'(H_ACTIVE);
    localparam logic [11:0] V_VIS_END  = 12'(V_ACTIVE);
    localparam logic [11:0] H_SYNC_BEG = 12'(H_ACTIVE + H_FRONT);
    localparam logic [11:0] H_SYNC_END = 12'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [11:0] V_SYNC_BEG = 12'(V_ACTIVE + V_FRONT);
    localparam logic [11:0] V_SYNC_END = 12'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [11:0] hcount_nxt;
    logic [11:0] vcount_nxt;

    ////////////////////////////////////////
    // Counter advance
    always_comb begin
        hcount_nxt = timing.hcount + 12'd1;
        vcount_nxt = timing.vcount;
        // End of line wraps h and steps v
        if (timing.hcount == H_LAST) begin
            hcount_nxt = '0;
            if (timing.vcount == V_LAST) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = timing.vcount + 12'd1;
            end
        end
    end

    // Sync and blank decoded from the next counts so they line up with them
    always_ff @(posedge clk) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing.hcount <= hcount_nxt;
            timing.vcount <= vcount_nxt;
            timing.hsync  <= (hcount_nxt >= H_SYNC_BEG) && (hcount_nxt < H_SYNC_END);
            timing.vsync  <= (vcount_nxt >= V_SYNC_BEG) && (vcount_nxt < V_SYNC_END);
            timing.hblnk  <= (hcount_nxt >= H_VIS_END);
            timing.vblnk  <= (vcount_nxt >= V_VIS_END);
        end
    end

    // Line counter stays inside the line total
    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst) timing.hcount <= H_LAST
    );

endmodule

//--- verilog/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    // Shift chain, stage 0 closest to the input
    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

//--- verilog/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  logic       clk,
    input  logic [2:0] code,
    input  logic [2:0] row,
    output logic [7:0] bits
);

    ////////////////////////////////////////
    // 8 glyphs of 8 rows each, MSB is the leftmost pixel
    logic [7:0] rom [0:63];

    initial begin
        $readmemh("verilog/glyphs.mem", rom);
    end

    // Address is glyph code then row
    logic [5:0] addr;

    assign addr = {code, row};

    // One cycle read latency
    always_ff @(posedge clk) begin
        bits <= rom[addr];
    end

endmodule

//--- verilog/text_box_render.sv
`timescale 1ns/1ps

module text_box_render #(
    parameter int BOX_X = 432,
    parameter int BOX_Y = 400
) (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::vga_timing_t timing,
    output vga_pkg::text_layer_t text_layer
);

    // Box extent in pixels, end bounds exclusive
    localparam int BOX_W = vga_pkg::BOX_COLS * vga_pkg::CELL_W;
    localparam int BOX_H = vga_pkg::BOX_ROWS * vga_pkg::CELL_H;
    localparam logic [11:0] X_BEG = 12'(BOX_X);
    localparam logic [11:0] X_END = 12'(BOX_X + BOX_W);
    localparam logic [11:0] Y_BEG = 12'(BOX_Y);
    localparam logic [11:0] Y_END = 12'(BOX_Y + BOX_H);

    logic        in_box;
    logic [11:0] rx;
    logic [11:0] ry;
    logic [3:0]  cell_col;
    logic [2:0]  cell_row;
    logic [6:0]  cell_idx;
    logic [2:0]  code;

    // Stage 1
    logic [2:0]  code_q;
    logic [2:0]  glyph_row_q;
    logic [2:0]  bit_q;
    logic        in_box_q;

    // Stage 2, alongside the ROM read
    logic [2:0]  bit_q2;
    logic        in_box_q2;
    logic [7:0]  glyph_bits;

    ////////////////////////////////////////
    // Hit test and cell addressing
    assign in_box = (timing.hcount >= X_BEG) && (timing.hcount < X_END) &&
                    (timing.vcount >= Y_BEG) && (timing.vcount < Y_END);
    assign rx = timing.hcount - X_BEG;
    assign ry = timing.vcount - Y_BEG;

    // 8 pixels per column, 16 lines per row
    assign cell_col = rx[6:3];
    assign cell_row = ry[6:4];

    // Row-major index, parked at 0 outside the box
    assign cell_idx = in_box ? {cell_row, cell_col} : 7'd0;
    assign code     = vga_pkg::BOX_TEXT[cell_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            code_q      <= '0;
            glyph_row_q <= '0;
            bit_q       <= '0;
            in_box_q    <= 1'b0;
            bit_q2      <= '0;
            in_box_q2   <= 1'b0;
        end else begin
            code_q      <= code;
            // Each glyph row shown on two lines
            glyph_row_q <= ry[3:1];
            bit_q       <= rx[2:0];
            in_box_q    <= in_box;
            bit_q2      <= bit_q;
            in_box_q2   <= in_box_q;
        end
    end

    ////////////////////////////////////////
    // Glyph fetch
    glyph_rom u_glyph_rom (
        .clk  (clk),
        .code (code_q),
        .row  (glyph_row_q),
        .bits (glyph_bits)
    );

    // Leftmost pixel is bit 7
    always_comb begin
        text_layer.in_box = in_box_q2;
        text_layer.lit    = in_box_q2 & glyph_bits[3'd7 - bit_q2];
    end

    // Only rows 0 to 4 exist inside the box
    a_cell_row: assert property (
        @(posedge clk) disable iff (rst)
        in_box |-> (cell_row < 3'(vga_pkg::BOX_ROWS))
    );

endmodule

//--- verilog/pointer_overlay.sv
`timescale 1ns/1ps

module pointer_overlay #(
    parameter int BOX_X = 432,
    parameter int BOX_Y = 400
) (
    input  logic                    clk,
    input  logic                    rst,
    input  vga_pkg::vga_timing_t    timing,
    input  logic [11:0]             mouse_xpos,
    input  logic [11:0]             mouse_ypos,
    input  logic                    mouse_left,
    output vga_pkg::pointer_layer_t pointer_layer
);

    localparam logic [11:0] X_BEG = 12'(BOX_X);
    localparam logic [11:0] X_END = 12'(BOX_X + vga_pkg::BOX_COLS * vga_pkg::CELL_W);
    localparam logic [11:0] Y_BEG = 12'(BOX_Y);
    localparam logic [11:0] Y_END = 12'(BOX_Y + vga_pkg::BOX_ROWS * vga_pkg::CELL_H);

    logic                    vsync_q;
    logic                    vsync_rise;
    logic [11:0]             x_s;
    logic [11:0]             y_s;
    logic                    btn_s;
    logic                    hover_now;
    vga_pkg::pointer_layer_t flags;
    vga_pkg::pointer_layer_t flags_q;

    ////////////////////////////////////////
    // Mouse snapshot, once per frame
    assign vsync_rise = timing.vsync & ~vsync_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            vsync_q <= 1'b0;
            x_s     <= '0;
            y_s     <= '0;
            btn_s   <= 1'b0;
        end else begin
            vsync_q <= timing.vsync;
            if (vsync_rise) begin
                x_s   <= mouse_xpos;
                y_s   <= mouse_ypos;
                btn_s <= mouse_left;
            end
        end
    end

    // Frame-constant hover from the snapshot
    assign hover_now = (x_s >= X_BEG) && (x_s < X_END) && (y_s >= Y_BEG) && (y_s < Y_END);

    always_comb begin
        // Crosshair on the sampled column and line
        flags.cursor  = (timing.hcount == x_s) || (timing.vcount == y_s);
        flags.hover   = hover_now;
        flags.pressed = hover_now & btn_s;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags;
        end
    end

    // Extra stage to match the text path latency
    pipe_delay #(
        .DEPTH (1),
        .T     (vga_pkg::pointer_layer_t)
    ) u_flag_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (flags_q),
        .dout (pointer_layer)
    );

    // Press only ever shown on top of hover
    a_press_hover: assert property (
        @(posedge clk) disable iff (rst)
        pointer_layer.pressed |-> pointer_layer.hover
    );

endmodule

//--- verilog/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    blank,
    input  vga_pkg::text_layer_t    text_layer,
    input  vga_pkg::pointer_layer_t pointer_layer,
    output vga_pkg::rgb_t           rgb
);

    vga_pkg::rgb_t rgb_nxt;

    ////////////////////////////////////////
    // Colour priority, highest first
    always_comb begin
        if (blank) begin
            rgb_nxt = vga_pkg::BLANK_COLOUR;
        end else if (pointer_layer.cursor) begin
            // Crosshair over everything visible
            rgb_nxt = vga_pkg::CURSOR_COLOUR;
        end else if (text_layer.in_box) begin
            if (text_layer.lit) begin
                rgb_nxt = vga_pkg::LETTER_COLOUR;
            end else if (pointer_layer.pressed) begin
                rgb_nxt = vga_pkg::PRESS_COLOUR;
            end else if (pointer_layer.hover) begin
                rgb_nxt = vga_pkg::HOVER_COLOUR;
            end else begin
                rgb_nxt = vga_pkg::TEXT_BG_COLOUR;
            end
        end else begin
            // Plain screen background
            rgb_nxt = vga_pkg::BG_COLOUR;
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_nxt;
        end
    end

endmodule

//--- verilog/text_overlay_top.sv
`timescale 1ns/1ps

module text_overlay_top #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23,
    parameter int BOX_X    = 432,
    parameter int BOX_Y    = 400
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [11:0]          mouse_xpos,
    input  logic [11:0]          mouse_ypos,
    input  logic                 mouse_left,
    output vga_pkg::vga_timing_t timing_out,
    output vga_pkg::rgb_t        rgb_out
);

    vga_pkg::vga_timing_t    timing_t0;
    vga_pkg::vga_timing_t    timing_t2;
    vga_pkg::text_layer_t    text_layer;
    vga_pkg::pointer_layer_t pointer_layer;

    ////////////////////////////////////////
    // Timing source
    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (
        .clk    (clk),
        .rst    (rst),
        .timing (timing_t0)
    );

    // Text and pointer paths, both 2 cycles
    text_box_render #(.BOX_X (BOX_X), .BOX_Y (BOX_Y)) u_text (
        .clk        (clk),
        .rst        (rst),
        .timing     (timing_t0),
        .text_layer (text_layer)
    );

    pointer_overlay #(.BOX_X (BOX_X), .BOX_Y (BOX_Y)) u_pointer (
        .clk           (clk),
        .rst           (rst),
        .timing        (timing_t0),
        .mouse_xpos    (mouse_xpos),
        .mouse_ypos    (mouse_ypos),
        .mouse_left    (mouse_left),
        .pointer_layer (pointer_layer)
    );

    ////////////////////////////////////////
    // Timing delay, tap at 2 for blanking, 3 at the output
    pipe_delay #(.DEPTH (2), .T (vga_pkg::vga_timing_t)) u_delay_t2 (
        .clk (clk), .rst (rst), .din (timing_t0), .dout (timing_t2)
    );

    pipe_delay #(.DEPTH (1), .T (vga_pkg::vga_timing_t)) u_delay_t3 (
        .clk (clk), .rst (rst), .din (timing_t2), .dout (timing_out)
    );

    pixel_mixer u_mixer (
        .clk           (clk),
        .rst           (rst),
        .blank         (timing_t2.hblnk | timing_t2.vblnk),
        .text_layer    (text_layer),
        .pointer_layer (pointer_layer),
        .rgb           (rgb_out)
    );

endmodule

//--- verification/tb_text_overlay.sv
`timescale 1ns/1ps

module tb_text_overlay;

    // Small frame so a run stays short
    localparam int H_ACTIVE = 200;
    localparam int H_FRONT  = 8;
    localparam int H_SYNC   = 16;
    localparam int H_BACK   = 16;
    localparam int V_ACTIVE = 120;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 5;
    localparam int BOX_X    = 40;
    localparam int BOX_Y    = 20;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int BOX_W        = vga_pkg::BOX_COLS * vga_pkg::CELL_W;
    localparam int BOX_H        = vga_pkg::BOX_ROWS * vga_pkg::CELL_H;
    // About two frames per mouse setting, 29 frames over all tests
    localparam int RUN_FRAMES   = 30;
    localparam int TIMEOUT_NS   = (RUN_FRAMES + 4) * FRAME_CYCLES * 10;

    // Colour classes for the per-frame tally
    localparam int C_OTHER  = 0;
    localparam int C_BG     = 1;
    localparam int C_TEXT   = 2;
    localparam int C_LETTER = 3;
    localparam int C_HOVER  = 4;
    localparam int C_PRESS  = 5;
    localparam int C_CURSOR = 6;

    logic                 clk;
    logic                 rst;
    logic [11:0]          mouse_xpos;
    logic [11:0]          mouse_ypos;
    logic                 mouse_left;
    vga_pkg::vga_timing_t timing_out;
    vga_pkg::rgb_t        rgb_out;

    logic [7:0]    glyph_mem [0:63];
    // Mouse values in force for the frame on timing_out
    logic [11:0]   snap_x;
    logic [11:0]   snap_y;
    logic          snap_btn;
    logic          vsync_prev;
    vga_pkg::rgb_t exp_rgb;
    logic          check_en;
    logic [31:0]   rnd;
    integer        seed;
    string         test_name;
    int            test_errs;
    int            expl_errs;
    int            err_base;
    int            pixel_errs;
    int            pixel_checks;
    int            tests_passed;
    int            tests_failed;
    int            seen [7];
    int            seen_base [7];

    text_overlay_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .BOX_X    (BOX_X),    .BOX_Y   (BOX_Y)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .mouse_xpos (mouse_xpos),
        .mouse_ypos (mouse_ypos),
        .mouse_left (mouse_left),
        .timing_out (timing_out),
        .rgb_out    (rgb_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog sized from the frame budget
    initial begin
        #(TIMEOUT_NS);
        $display("Run stopped by the watchdog, the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////
    // Expected colour of one pixel
    function automatic vga_pkg::rgb_t ref_colour(input int h, input int v, input int mx,
                                                 input int my, input logic btn);
        int         rx;
        int         ry;
        int         code;
        int         row;
        logic       in_box;
        logic       hover;
        logic [7:0] bits;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;
        end
        if (h == mx || v == my) begin
            return vga_pkg::CURSOR_COLOUR;
        end
        in_box = (h >= BOX_X) && (h < BOX_X + BOX_W) && (v >= BOX_Y) && (v < BOX_Y + BOX_H);
        if (!in_box) begin
            return vga_pkg::BG_COLOUR;
        end
        rx = h - BOX_X;
        ry = v - BOX_Y;
        // Cell code, then the doubled glyph row
        code = int'(vga_pkg::BOX_TEXT[(ry / 16) * 16 + rx / 8]);
        row  = (ry % 16) / 2;
        bits = glyph_mem[code * 8 + row];
        if (bits[7 - rx % 8]) begin
            return vga_pkg::LETTER_COLOUR;
        end
        hover = (mx >= BOX_X) && (mx < BOX_X + BOX_W) && (my >= BOX_Y) && (my < BOX_Y + BOX_H);
        if (hover && btn) begin
            return vga_pkg::PRESS_COLOUR;
        end
        if (hover) begin
            return vga_pkg::HOVER_COLOUR;
        end
        return vga_pkg::TEXT_BG_COLOUR;
    endfunction

    function automatic int colour_class(input vga_pkg::rgb_t c);
        if (c == vga_pkg::BG_COLOUR)      return C_BG;
        if (c == vga_pkg::TEXT_BG_COLOUR) return C_TEXT;
        if (c == vga_pkg::LETTER_COLOUR)  return C_LETTER;
        if (c == vga_pkg::HOVER_COLOUR)   return C_HOVER;
        if (c == vga_pkg::PRESS_COLOUR)   return C_PRESS;
        if (c == vga_pkg::CURSOR_COLOUR)  return C_CURSOR;
        return C_OTHER;
    endfunction

    ////////////////////////////////////////
    // Pixel compare on every cycle
    always @(posedge clk) begin
        if (rst) begin
            snap_x       <= '0;
            snap_y       <= '0;
            snap_btn     <= 1'b0;
            vsync_prev   <= 1'b0;
            pixel_errs   <= 0;
            pixel_checks <= 0;
            for (int k = 0; k < 7; k++) begin
                seen[k] <= 0;
            end
        end else begin
            // DUT takes the mouse at vsync rise, inputs are steady around it
            if (timing_out.vsync && !vsync_prev) begin
                snap_x   <= mouse_xpos;
                snap_y   <= mouse_ypos;
                snap_btn <= mouse_left;
            end
            vsync_prev <= timing_out.vsync;
            if (check_en) begin
                exp_rgb = ref_colour(int'(timing_out.hcount), int'(timing_out.vcount),
                                     int'(snap_x), int'(snap_y), snap_btn);
                pixel_checks <= pixel_checks + 1;
                seen[colour_class(rgb_out)] <= seen[colour_class(rgb_out)] + 1;
                if (rgb_out != exp_rgb) begin
                    pixel_errs <= pixel_errs + 1;
                    if (pixel_errs - err_base < 20) begin
                        $display("[ERROR] %s: pixel (%0d,%0d) expected %03h actual %03h",
                                 test_name, timing_out.hcount, timing_out.vcount,
                                 exp_rgb, rgb_out);
                    end else if (pixel_errs - err_base == 20) begin
                        $display("%s: more pixel mismatches, counted without a line each",
                                 test_name);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Test helpers
    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        err_base  = pixel_errs;
    endtask

    task automatic finish_test();
        int n;
        n = test_errs + (pixel_errs - err_base);
        expl_errs = expl_errs + test_errs;
        if (n == 0) begin
            tests_passed = tests_passed + 1;
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("[FAIL] %s with %0d errors", test_name, n);
        end
    endtask

    task automatic report_value(input string item, input int expv, input int actv);
        test_errs = test_errs + 1;
        $display("[ERROR] %s: %s expected %0d actual %0d", test_name, item, expv, actv);
    endtask

    // Returns on the edge where timing_out shows this pixel
    task automatic wait_pixel(input int h, input int v);
        @(posedge clk);
        while (!(int'(timing_out.hcount) == h && int'(timing_out.vcount) == v)) begin
            @(posedge clk);
        end
    endtask

    task automatic drive_mouse(input logic [11:0] x, input logic [11:0] y, input logic b);
        mouse_xpos <= x;
        mouse_ypos <= y;
        mouse_left <= b;
    endtask

    // First vblank line, well before vsync even at the DUT input side
    task automatic set_mouse(input logic [11:0] x, input logic [11:0] y, input logic b);
        wait_pixel(0, V_ACTIVE);
        drive_mouse(x, y, b);
    endtask

    task automatic run_frame();
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        seen_base = seen;
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
    endtask

    task automatic expect_seen(input string item, input int cls);
        if (seen[cls] - seen_base[cls] == 0) begin
            test_errs = test_errs + 1;
            $display("%s: no %s pixels appeared in the frame", test_name, item);
        end
    endtask

    task automatic expect_none(input string item, input int cls);
        if (seen[cls] - seen_base[cls] != 0) begin
            report_value({item, " pixel count"}, 0, seen[cls] - seen_base[cls]);
        end
    endtask

    // Counter order, blank flags, blank colour and sync pulse shape over one frame
    task automatic check_sync_frame();
        int hs_run;
        int vs_run;
        int hs_pulses;
        int vs_pulses;
        int hi;
        int vi;
        int exp_h;
        int exp_v;
        hs_run    = 0;
        vs_run    = 0;
        hs_pulses = 0;
        vs_pulses = 0;
        exp_h     = 0;
        exp_v     = 0;
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        repeat (FRAME_CYCLES) begin
            @(posedge clk);
            hi = int'(timing_out.hcount);
            vi = int'(timing_out.vcount);
            if (hi != exp_h || vi != exp_v) begin
                report_value("pixel index in frame", exp_v * H_TOTAL + exp_h,
                             vi * H_TOTAL + hi);
            end
            if (timing_out.hblnk != (hi >= H_ACTIVE)) begin
                report_value("hblnk", int'(hi >= H_ACTIVE), int'(timing_out.hblnk));
            end
            if (timing_out.vblnk != (vi >= V_ACTIVE)) begin
                report_value("vblnk", int'(vi >= V_ACTIVE), int'(timing_out.vblnk));
            end
            if ((hi >= H_ACTIVE || vi >= V_ACTIVE) && rgb_out != '0) begin
                report_value("blanked pixel colour", 0, int'(rgb_out));
            end
            if (timing_out.hsync) begin
                if (hs_run == 0 && hi != H_ACTIVE + H_FRONT) begin
                    report_value("hsync start column", H_ACTIVE + H_FRONT, hi);
                end
                hs_run = hs_run + 1;
            end else if (hs_run != 0) begin
                if (hs_run != H_SYNC) begin
                    report_value("hsync width", H_SYNC, hs_run);
                end
                hs_pulses = hs_pulses + 1;
                hs_run    = 0;
            end
            if (timing_out.vsync) begin
                if (vs_run == 0 && vi != V_ACTIVE + V_FRONT) begin
                    report_value("vsync start line", V_ACTIVE + V_FRONT, vi);
                end
                vs_run = vs_run + 1;
            end else if (vs_run != 0) begin
                // Counted in cycles, whole lines expected
                if (vs_run != V_SYNC * H_TOTAL) begin
                    report_value("vsync width in cycles", V_SYNC * H_TOTAL, vs_run);
                end
                vs_pulses = vs_pulses + 1;
                vs_run    = 0;
            end
            exp_h = exp_h + 1;
            if (exp_h == H_TOTAL) begin
                exp_h = 0;
                exp_v = exp_v + 1;
            end
        end
        if (hs_pulses != V_TOTAL) begin
            report_value("hsync pulses per frame", V_TOTAL, hs_pulses);
        end
        if (vs_pulses != 1) begin
            report_value("vsync pulses per frame", 1, vs_pulses);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    initial begin
        rst          = 1'b1;
        mouse_xpos   = '0;
        mouse_ypos   = '0;
        mouse_left   = 1'b0;
        check_en     = 1'b0;
        seed         = 84823;
        test_errs    = 0;
        expl_errs    = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("verilog/glyphs.mem", glyph_mem);

        start_test("reset_and_sync");
        repeat (10) @(posedge clk);
        if (timing_out != '0) begin
            report_value("timing_out during reset", 0, int'(timing_out));
        end
        if (rgb_out != '0) begin
            report_value("rgb_out during reset", 0, int'(rgb_out));
        end
        rst <= 1'b0;
        // Three pixels in flight before the first real output
        repeat (3) @(posedge clk);
        check_en <= 1'b1;
        check_sync_frame();
        finish_test();

        start_test("mouse_outside");
        set_mouse(12'd190, 12'd110, 1'b0);
        run_frame();
        expect_seen("letter", C_LETTER);
        expect_seen("text background", C_TEXT);
        expect_seen("screen background", C_BG);
        expect_seen("cursor", C_CURSOR);
        expect_none("hover", C_HOVER);
        expect_none("press", C_PRESS);
        finish_test();

        start_test("hover");
        set_mouse(12'd100, 12'd50, 1'b0);
        run_frame();
        expect_seen("hover", C_HOVER);
        expect_seen("letter", C_LETTER);
        expect_seen("cursor", C_CURSOR);
        expect_none("text background", C_TEXT);
        expect_none("press", C_PRESS);
        finish_test();

        start_test("button_press");
        set_mouse(12'd70, 12'd60, 1'b1);
        run_frame();
        expect_seen("press", C_PRESS);
        expect_seen("letter", C_LETTER);
        expect_none("hover", C_HOVER);
        expect_none("text background", C_TEXT);
        // Button held away from the box
        set_mouse(12'd190, 12'd110, 1'b1);
        run_frame();
        expect_seen("text background", C_TEXT);
        expect_seen("screen background", C_BG);
        expect_none("press", C_PRESS);
        expect_none("hover", C_HOVER);
        finish_test();

        start_test("mid_frame_change");
        set_mouse(12'd60, 12'd30, 1'b0);
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        seen_base = seen;
        wait_pixel(10, 60);
        drive_mouse(12'd150, 12'd90, 1'b1);
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        // Old snapshot holds to the end of this frame
        expect_seen("hover", C_HOVER);
        expect_none("press", C_PRESS);
        seen_base = seen;
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        expect_seen("press", C_PRESS);
        expect_none("hover", C_HOVER);
        finish_test();

        start_test("random_frames");
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            set_mouse(12'(rnd[7:0] % 8'd220), 12'(rnd[15:8] % 8'd130), rnd[16]);
            run_frame();
        end
        finish_test();

        // Let the last compares land
        check_en <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Tests %0d passed, %0d failed, %0d pixels checked, %0d errors",
                 tests_passed, tests_failed, pixel_checks, expl_errs + pixel_errs);
        if (tests_failed == 0 && expl_errs + pixel_errs == 0 && pixel_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog/glyphs.mem
// One byte per glyph row, MSB is the leftmost pixel
// 8 rows per glyph, codes 0 to 7 are blank H E L O W R D
00
00
00
00
00
00
00
00
66
66
66
7E
66
66
66
00
7E
60
60
7C
60
60
7E
00
60
60
60
60
60
60
7E
00
3C
66
66
66
66
66
3C
00
63
63
63
6B
7F
77
63
00
7C
66
66
7C
78
6C
66
00
78
6C
66
66
66
6C
78
00

//--- text_overlay_top.f
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/pipe_delay.sv
verilog/glyph_rom.sv
verilog/text_box_render.sv
verilog/pointer_overlay.sv
verilog/pixel_mixer.sv
verilog/text_overlay_top.sv
verification/tb_text_overlay.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator from the project root, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f text_overlay_top.f \
    --top-module tb_text_overlay -o tb_text_overlay \
    && ./obj_dir/tb_text_overlay | tee sim.log \
    || echo "Build or simulation did not complete"
grep -qx "All checks passed" sim.log && echo "Result PASS" && exit 0 \
    || { echo "Result FAIL"; exit 1; }
